/* source/vdp_timing_pkg.sv */
////////////////////////////////////////
// Raster timing definitions
// Positions, sync flags and pipeline lag
////////////////////////////////////////

`default_nettype none

package vdp_timing_pkg;

  // Column or row of the raster
  typedef logic [8:0] coord_t;

  // Sync flags as produced by the counter
  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
  } sync_t;

  // Cycles from raster position to pixel at the outputs
  localparam int PIPE_LAG = 4;

endpackage

`default_nettype wire

/* source/vdp_regs_pkg.sv */
////////////////////////////////////////
// CPU register map and color tables
// APB regions, register fields, palette
////////////////////////////////////////

`default_nettype none

package vdp_regs_pkg;

  typedef logic [11:0] apb_addr_t; // Byte address
  typedef logic [3:0]  color_t;    // Palette index
  typedef logic [23:0] rgb_t;      // {R,G,B}

  localparam int BGM_WORDS = 512;
  localparam int CHR_BYTES = 1024;

  // Region bases
  localparam apb_addr_t BGM_BASE = 12'h000;
  localparam apb_addr_t CHR_BASE = 12'h400; // Write-only
  localparam apb_addr_t REG_BASE = 12'h800;

  // Register offsets within REG_BASE
  localparam apb_addr_t REG_CTRL   = 12'd0;
  localparam apb_addr_t REG_COLORS = 12'd1;
  localparam apb_addr_t REG_BORDER = 12'd2;

  // Field positions
  localparam int CTRL_EN_BIT   = 0;
  localparam int COLORS_BG_LSB = 0;
  localparam int COLORS_FG_LSB = 4;
  localparam int BORDER_LSB    = 0;

  // RGB connector levels
  localparam rgb_t PALETTE_RGB [16] = '{
    24'h0000a0, 24'h000000, 24'h0000f5, 24'ha000eb,
    24'h00f500, 24'h96eb96, 24'h00ebeb, 24'h00a000,
    24'hf50000, 24'heba000, 24'heb00eb, 24'heb9696,
    24'hebeb00, 24'ha0a000, 24'h969696, 24'he1e1e1
  };

endpackage

`default_nettype wire

/* source/bgm_port_if.sv */
////////////////////////////////////////
// BGM requester port
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface bgm_port_if;
  logic       req;   // Held until gnt
  logic       we;
  logic [8:0] addr;
  logic [7:0] wdata;
  logic       gnt;
  logic [7:0] rdata; // Valid the cycle after gnt

  modport requester (output req, we, addr, wdata, input gnt, rdata);
  modport arbiter (input req, we, addr, wdata, output gnt, rdata);
endinterface

`default_nettype wire

/* source/video_counter.sv */
////////////////////////////////////////
// Video counter
// Raster position and raw sync flags
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module video_counter
  import vdp_timing_pkg::*;
#(
  parameter int H_TOTAL      = 260,
  parameter int V_TOTAL      = 263,
  parameter int H_ACTIVE     = 208,
  parameter int V_ACTIVE     = 232,
  parameter int H_SYNC_START = 240,
  parameter int H_SYNC_LEN   = 20,
  parameter int V_SYNC_START = 257,
  parameter int V_SYNC_LEN   = 3
) (
  input  logic   CLK,
  input  logic   reset,
  output coord_t col,
  output coord_t row,
  output sync_t  raw_sync
);

  always_ff @(posedge CLK) begin
    if (reset) begin
      col <= '0;
      row <= '0;
    end else if (col == coord_t'(H_TOTAL - 1)) begin
      col <= '0;
      row <= (row == coord_t'(V_TOTAL - 1)) ? '0 : row + 1'b1; // Frame wrap
    end else begin
      col <= col + 1'b1;
    end
  end

  // Windows straight from the counters
  assign raw_sync.de = (col < H_ACTIVE) && (row < V_ACTIVE);
  assign raw_sync.hs = (col >= H_SYNC_START) && (col < H_SYNC_START + H_SYNC_LEN);
  assign raw_sync.vs = (row >= V_SYNC_START) && (row < V_SYNC_START + V_SYNC_LEN);

  a_col_range: assert property (@(posedge CLK) disable iff (reset) col < H_TOTAL);

endmodule

`default_nettype wire

/* source/cpu_bus_bridge.sv */
////////////////////////////////////////
// CPU bus bridge
// APB decode, registers, CHR and BGM access
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_bus_bridge
  import vdp_regs_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  apb_addr_t  paddr,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pready,
  output logic       pslverr,
  bgm_port_if.requester bgm,
  output logic       chr_we,
  output logic [9:0] chr_addr,
  output logic [7:0] chr_wdata,
  output logic       display_en,
  output color_t     fg,
  output color_t     bg,
  output color_t     border
);

  logic      access, sel_bgm, sel_chr, sel_reg, err, gnt_d;
  apb_addr_t bgm_off, chr_off, reg_off;
  logic [7:0] rd_mux;

  ////////////////////////////////////////
  // Address decode

  assign access  = psel & penable;
  assign bgm_off = paddr - BGM_BASE;
  assign chr_off = paddr - CHR_BASE;
  assign reg_off = paddr - REG_BASE;
  assign sel_bgm = bgm_off < BGM_WORDS;
  assign sel_chr = chr_off < CHR_BYTES;
  assign sel_reg = (reg_off == REG_CTRL) || (reg_off == REG_COLORS) || (reg_off == REG_BORDER);
  assign err     = ~(sel_bgm | sel_chr | sel_reg) | (sel_chr & ~pwrite); // CHR is write-only

  // Registers
  always_ff @(posedge CLK) begin
    if (reset) begin
      display_en <= 1'b0;
      fg <= '0;
      bg <= '0;
      border <= '0;
    end else if (access & pwrite & sel_reg) begin
      case (reg_off)
        REG_CTRL:   display_en <= pwdata[CTRL_EN_BIT];
        REG_COLORS: begin
          fg <= pwdata[COLORS_FG_LSB +: 4];
          bg <= pwdata[COLORS_BG_LSB +: 4];
        end
        default:    border <= pwdata[BORDER_LSB +: 4];
      endcase
    end
  end

  always_comb begin
    rd_mux = bgm.rdata;
    if (sel_reg) begin
      case (reg_off)
        REG_CTRL:   rd_mux = 8'(display_en) << CTRL_EN_BIT;
        REG_COLORS: rd_mux = (8'(fg) << COLORS_FG_LSB) | (8'(bg) << COLORS_BG_LSB);
        default:    rd_mux = 8'(border) << BORDER_LSB;
      endcase
    end
  end

  // CHR writes go straight through in the access cycle
  assign chr_we    = access & pwrite & sel_chr;
  assign chr_addr  = chr_off[9:0];
  assign chr_wdata = pwdata;

  ////////////////////////////////////////
  // BGM request and completion

  always_ff @(posedge CLK) begin
    if (reset) gnt_d <= 1'b0;
    else       gnt_d <= bgm.gnt;
  end

  assign bgm.req   = access & sel_bgm & ~gnt_d;
  assign bgm.we    = pwrite;
  assign bgm.addr  = bgm_off[8:0];
  assign bgm.wdata = pwdata;

  assign pready  = access & (~sel_bgm | gnt_d);
  assign pslverr = access & err;
  assign prdata  = (access & ~pwrite & ~err) ? rd_mux : 8'h00;

  a_ready_in_access: assert property (@(posedge CLK) disable iff (reset)
    pready |-> psel && penable);
  a_req_drops: assert property (@(posedge CLK) disable iff (reset) bgm.gnt |=> !bgm.req);

endmodule

`default_nettype wire

/* source/bgm_shared_ram.sv */
////////////////////////////////////////
// Background memory
// Tile map store with fixed-priority arbiter
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bgm_shared_ram
  import vdp_regs_pkg::*;
(
  input logic         CLK,
  bgm_port_if.arbiter cpu,
  bgm_port_if.arbiter ren
);

  logic [7:0] mem [BGM_WORDS];
  logic [8:0] addr;
  logic [7:0] wdata;
  logic       we;
  logic [7:0] rd_q;

  ////////////////////////////////////////
  // Arbiter

  // Renderer always wins, CPU retries next cycle
  assign ren.gnt = ren.req;
  assign cpu.gnt = cpu.req & ~ren.req;

  always_comb begin
    if (ren.req) begin
      addr  = ren.addr;
      wdata = ren.wdata;
      we    = ren.we;
    end else begin
      addr  = cpu.addr;
      wdata = cpu.wdata;
      we    = cpu.gnt & cpu.we;
    end
  end

  ////////////////////////////////////////
  // Storage

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rd_q <= mem[addr]; // Registered read port
  end

  // One read port, shared by both requesters
  assign cpu.rdata = rd_q;
  assign ren.rdata = rd_q;

  a_one_grant: assert property (@(posedge CLK) !(cpu.gnt && ren.gnt));

endmodule

`default_nettype wire

/* source/tile_renderer.sv */
////////////////////////////////////////
// Tile renderer
// BGM fetch, CHR lookup, shifter, palette
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tile_renderer
  import vdp_timing_pkg::*, vdp_regs_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  coord_t     col,
  input  coord_t     row,
  input  sync_t      raw_sync,
  bgm_port_if.requester bgm,
  input  logic       chr_we,
  input  logic [9:0] chr_addr,
  input  logic [7:0] chr_wdata,
  input  logic       display_en,
  input  color_t     fg,
  input  color_t     bg,
  input  color_t     border,
  output logic       de,
  output logic       hs,
  output logic       vs,
  output rgb_t       rgb
);

  // Last stage feeds the output registers
  localparam int STAGES = PIPE_LAG - 1;

  logic [7:0] chr_mem [CHR_BYTES];
  logic [7:0] chr_q;
  logic [7:0] shifter;
  sync_t      sync_d [STAGES];
  coord_t     col_d [STAGES];
  coord_t     row_d [STAGES];
  color_t     pix_idx;

  ////////////////////////////////////////
  // Tile fetch

  assign bgm.req   = (col[2:0] == 3'd0); // Once per 8-pixel cell
  assign bgm.we    = 1'b0;
  assign bgm.addr  = {row[6:3], col[7:3]}; // 32 tiles per row
  assign bgm.wdata = '0;

  always_ff @(posedge CLK) begin
    if (chr_we) begin
      chr_mem[chr_addr] <= chr_wdata;
    end
    chr_q <= chr_mem[{bgm.rdata[6:0], row_d[0][2:0]}]; // Code arrives one cycle after fetch
  end

  // Pattern shifter, MSB is the leftmost pixel
  always_ff @(posedge CLK) begin
    if (col_d[1][2:0] == 3'd0) shifter <= chr_q;
    else                       shifter <= {shifter[6:0], 1'b0};
  end

  ////////////////////////////////////////
  // Position and sync delay line

  always_ff @(posedge CLK) begin
    col_d[0] <= col;
    row_d[0] <= row;
    for (int i = 1; i < STAGES; i++) begin
      col_d[i] <= col_d[i-1];
      row_d[i] <= row_d[i-1];
    end
  end

  always_comb begin
    if (!display_en)     pix_idx = border;
    else if (shifter[7]) pix_idx = fg;
    else                 pix_idx = bg;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < STAGES; i++) sync_d[i] <= '0;
      de  <= 1'b0;
      hs  <= 1'b0;
      vs  <= 1'b0;
      rgb <= '0;
    end else begin
      sync_d[0] <= raw_sync;
      for (int i = 1; i < STAGES; i++) sync_d[i] <= sync_d[i-1];
      de  <= sync_d[STAGES-1].de;
      hs  <= sync_d[STAGES-1].hs;
      vs  <= sync_d[STAGES-1].vs;
      rgb <= sync_d[STAGES-1].de ? PALETTE_RGB[pix_idx] : '0; // Black outside DE
    end
  end

  // Fetch slot must never lose to the CPU
  a_ren_granted: assert property (@(posedge CLK) disable iff (reset) bgm.req |-> bgm.gnt);

endmodule

`default_nettype wire

/* source/vdp_top.sv */
////////////////////////////////////////
// Character video display processor
// APB slave, shared BGM, tile renderer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vdp_top
  import vdp_timing_pkg::*, vdp_regs_pkg::*;
#(
  parameter int H_TOTAL      = 260,
  parameter int V_TOTAL      = 263,
  parameter int H_ACTIVE     = 208, // Multiple of 8
  parameter int V_ACTIVE     = 232,
  parameter int H_SYNC_START = 240,
  parameter int H_SYNC_LEN   = 20,
  parameter int V_SYNC_START = 257,
  parameter int V_SYNC_LEN   = 3
) (
  input  logic      CLK,
  input  logic      reset,
  // APB slave
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic      pready,
  output logic      pslverr,
  // Video out
  output logic      de,
  output logic      hs,
  output logic      vs,
  output rgb_t      rgb
);

  coord_t     col;
  coord_t     row;
  sync_t      raw_sync;
  logic       chr_we;
  logic [9:0] chr_addr;
  logic [7:0] chr_wdata;
  logic       display_en;
  color_t     fg;
  color_t     bg;
  color_t     border;

  bgm_port_if bgm_cpu ();
  bgm_port_if bgm_ren ();

  video_counter #(
    .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
  ) u_counter (
    .CLK(CLK), .reset(reset), .col(col), .row(row), .raw_sync(raw_sync)
  );

  cpu_bus_bridge u_bridge (
    .CLK(CLK), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .bgm(bgm_cpu.requester),
    .chr_we(chr_we), .chr_addr(chr_addr), .chr_wdata(chr_wdata),
    .display_en(display_en), .fg(fg), .bg(bg), .border(border)
  );

  bgm_shared_ram u_bgm (.CLK(CLK), .cpu(bgm_cpu.arbiter), .ren(bgm_ren.arbiter));

  tile_renderer u_renderer (
    .CLK(CLK), .reset(reset), .col(col), .row(row), .raw_sync(raw_sync),
    .bgm(bgm_ren.requester),
    .chr_we(chr_we), .chr_addr(chr_addr), .chr_wdata(chr_wdata),
    .display_en(display_en), .fg(fg), .bg(bg), .border(border),
    .de(de), .hs(hs), .vs(vs), .rgb(rgb)
  );

endmodule

`default_nettype wire

/* verif/vdp_tb.sv */
////////////////////////////////////////
// Display processor testbench
// APB traffic, pixel and sync checks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vdp_tb
  import vdp_regs_pkg::*;
();

  localparam int H_TOTAL = 80;
  localparam int V_TOTAL = 40;
  localparam int H_ACTIVE = 64;
  localparam int V_ACTIVE = 32;
  localparam int H_SYNC_START = 68;
  localparam int H_SYNC_LEN = 6;
  localparam int V_SYNC_START = 34;
  localparam int V_SYNC_LEN = 2;
  localparam int CLK_PERIOD = 40;
  localparam int RUN_CYCLES = 6 * H_TOTAL * V_TOTAL + 2000; // Frames plus bus traffic

  logic       CLK;
  logic       reset;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  logic [7:0] pwdata;
  logic [7:0] prdata;
  logic       pready;
  logic       pslverr;
  logic       de;
  logic       hs;
  logic       vs;
  rgb_t       rgb;

  // Shadow state of the DUT
  logic [7:0] bgm_shadow [BGM_WORDS];
  logic [7:0] chr_shadow [CHR_BYTES];
  logic       shadow_en;
  color_t     shadow_fg;
  color_t     shadow_bg;
  color_t     shadow_border;

  logic [31:0] rng_state = 32'h9dfb42ce;
  int          checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  // Monitor state
  logic pixel_check;
  int   pix_checked;
  logic de_q, hs_q, vs_q, frame_seen, frame_rise;
  int   x_pos, line_y, hs_len, vs_len;
  event frame_start;

  vdp_top #(
    .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
  ) u_dut (
    .CLK(CLK), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .de(de), .hs(hs), .vs(vs), .rgb(rgb)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Reference model and compare tasks

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic rgb_t expected_rgb(input int x, input int y);
    int         code;
    logic [7:0] pattern;
    color_t     idx;
    code = bgm_shadow[(y / 8) * 32 + x / 8] & 8'h7f; // Bit 7 of the tile code is ignored
    pattern = chr_shadow[code * 8 + y % 8];
    if (!shadow_en)              idx = shadow_border;
    else if (pattern[7 - x % 8]) idx = shadow_fg;
    else                         idx = shadow_bg;
    return PALETTE_RGB[idx];
  endfunction

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %06h expected %06h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      value_errors++;
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // APB master

  task automatic apb_transfer(input apb_addr_t addr, input logic wr, input logic [7:0] wdata,
                              output logic [7:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge CLK);
    paddr = addr;
    pwrite = wr;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge CLK);
    penable = 1'b1;
    @(posedge CLK);
    while (pready !== 1'b1 && waits < 16) begin
      waits++;
      @(posedge CLK);
    end
    if (pready !== 1'b1) begin
      other_errors++;
      $display("Access to %03h at %0t never completed, pready stayed low", addr, $time);
    end
    rdata = prdata; // Sampled at the completing edge
    err = pslverr;
    @(negedge CLK);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [7:0] data, input logic exp_err);
    logic [7:0] unused;
    logic       err;
    apb_transfer(addr, 1'b1, data, unused, err);
    check_flag($sformatf("pslverr write %03h", addr), err, exp_err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [7:0] data, input logic exp_err);
    logic err;
    apb_transfer(addr, 1'b0, 8'h00, data, err);
    check_flag($sformatf("pslverr read %03h", addr), err, exp_err);
  endtask

  // Checks every active pixel from one vs rise to the next
  task automatic compare_frame();
    @(frame_start);
    pix_checked = 0;
    pixel_check = 1'b1;
    @(frame_start);
    pixel_check = 1'b0;
    check_count("pixels per frame", pix_checked, H_ACTIVE * V_ACTIVE);
  endtask

  ////////////////////////////////////////
  // Output monitor

  always @(posedge CLK) begin
    if (reset) begin
      {de_q, hs_q, vs_q, frame_seen, frame_rise} = '0;
      x_pos = 0;
      line_y = 0;
      hs_len = 0;
      vs_len = 0;
    end else begin
      if (de && !de_q) x_pos = 0;
      else if (de)     x_pos++;
      if (de && pixel_check) begin
        check_rgb($sformatf("rgb(%0d,%0d)", x_pos, line_y), rgb, expected_rgb(x_pos, line_y));
        pix_checked++;
      end
      if (!de && frame_seen) check_rgb("rgb outside de", rgb, '0);
      if (!de && de_q) begin
        if (frame_seen) check_count("de cycles per line", x_pos + 1, H_ACTIVE);
        line_y++;
      end
      if (hs) hs_len++;
      if (!hs && hs_q) begin
        if (frame_seen) check_count("hs cycles", hs_len, H_SYNC_LEN);
        hs_len = 0;
      end
      if (vs) vs_len++;
      if (!vs && vs_q) begin
        if (frame_seen) check_count("vs cycles", vs_len, V_SYNC_LEN * H_TOTAL);
        vs_len = 0;
      end
      frame_rise = vs && !vs_q;
      if (frame_rise) begin
        if (frame_seen) check_count("de lines per frame", line_y, V_ACTIVE);
        frame_seen = 1'b1;
      end
      if (vs) line_y = 0; // Lines count from the vs pulse
      de_q = de;
      hs_q = hs;
      vs_q = vs;
      if (frame_rise) -> frame_start;
    end
  end

  ////////////////////////////////////////
  // Stimulus

  initial begin
    logic [7:0]  data;
    logic [31:0] r;
    logic [8:0]  addr_list [24];
    int          a;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    pixel_check = 1'b0;
    pix_checked = 0;
    shadow_en = 1'b0;
    shadow_fg = '0;
    shadow_bg = '0;
    shadow_border = '0;
    for (int i = 0; i < BGM_WORDS; i++) bgm_shadow[i] = '0;
    for (int i = 0; i < CHR_BYTES; i++) chr_shadow[i] = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;

    // Reset state
    @(posedge CLK);
    check_flag("de", de, 1'b0);
    check_flag("hs", hs, 1'b0);
    check_flag("vs", vs, 1'b0);
    check_rgb("rgb", rgb, '0);
    check_flag("pready", pready, 1'b0);
    apb_read(REG_BASE + REG_CTRL, data, 1'b0);
    check_data("ctrl after reset", data, 8'h00);
    apb_read(REG_BASE + REG_COLORS, data, 1'b0);
    check_data("colors after reset", data, 8'h00);
    apb_read(REG_BASE + REG_BORDER, data, 1'b0);
    check_data("border after reset", data, 8'h00);

    // Register fields and error responses
    apb_write(REG_BASE + REG_CTRL, 8'hff, 1'b0);
    apb_read(REG_BASE + REG_CTRL, data, 1'b0);
    check_data("ctrl readback", data, 8'h01);
    apb_write(REG_BASE + REG_COLORS, 8'ha5, 1'b0);
    apb_read(REG_BASE + REG_COLORS, data, 1'b0);
    check_data("colors readback", data, 8'ha5);
    apb_write(REG_BASE + REG_BORDER, 8'hf3, 1'b0);
    apb_read(REG_BASE + REG_BORDER, data, 1'b0);
    check_data("border readback", data, 8'h03);
    apb_write(12'h300, 8'h5a, 1'b1);
    apb_read(12'h300, data, 1'b1);
    check_data("unmapped read 300", data, 8'h00);
    apb_read(REG_BASE + 12'h003, data, 1'b1);
    check_data("unmapped read 803", data, 8'h00);
    apb_read(12'hc00, data, 1'b1);
    check_data("unmapped read c00", data, 8'h00);
    apb_read(CHR_BASE + 12'h056, data, 1'b1);
    check_data("chr read", data, 8'h00);

    // Random BGM traffic while the display runs
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      addr_list[i] = r[24:16];
      bgm_shadow[r[24:16]] = r[7:0];
      apb_write(BGM_BASE + apb_addr_t'(r[24:16]), r[7:0], 1'b0);
    end
    for (int i = 0; i < 24; i++) begin
      apb_read(BGM_BASE + apb_addr_t'(addr_list[i]), data, 1'b0);
      check_data($sformatf("bgm[%03h]", addr_list[i]), data, bgm_shadow[addr_list[i]]);
    end

    // Tile map with codes 0 to 15, bit 7 set at random
    for (int ty = 0; ty < V_ACTIVE / 8; ty++) begin
      for (int tx = 0; tx < H_ACTIVE / 8; tx++) begin
        r = next_rand();
        a = ty * 32 + tx;
        bgm_shadow[a] = {r[31], 3'b000, r[19:16]};
        apb_write(BGM_BASE + apb_addr_t'(a), bgm_shadow[a], 1'b0);
      end
    end
    for (int i = 0; i < 128; i++) begin
      r = next_rand();
      chr_shadow[i] = r[23:16];
      apb_write(CHR_BASE + apb_addr_t'(i), r[23:16], 1'b0);
    end
    r = next_rand();
    shadow_fg = r[7:4];
    shadow_bg = ~r[7:4]; // Never equal to fg
    shadow_border = r[11:8];
    shadow_en = 1'b1;
    apb_write(REG_BASE + REG_COLORS, {shadow_fg, shadow_bg}, 1'b0);
    apb_write(REG_BASE + REG_BORDER, {4'h0, shadow_border}, 1'b0);
    apb_write(REG_BASE + REG_CTRL, 8'h01, 1'b0);
    compare_frame();

    // Border only
    shadow_en = 1'b0;
    apb_write(REG_BASE + REG_CTRL, 8'h00, 1'b0);
    compare_frame();

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (RUN_CYCLES) @(posedge CLK);
    $display("Run did not finish within %0d cycles", RUN_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* vdp_top.f */
source/vdp_timing_pkg.sv
source/vdp_regs_pkg.sv
source/bgm_port_if.sv
source/video_counter.sv
source/cpu_bus_bridge.sv
source/bgm_shared_ram.sv
source/tile_renderer.sv
source/vdp_top.sv
verif/vdp_tb.sv

/* Bender.yml */
package:
  name: vdp

sources:
  - source/vdp_timing_pkg.sv
  - source/vdp_regs_pkg.sv
  - source/bgm_port_if.sv
  - source/video_counter.sv
  - source/cpu_bus_bridge.sv
  - source/bgm_shared_ram.sv
  - source/tile_renderer.sv
  - source/vdp_top.sv
  - target: test
    files:
      - verif/vdp_tb.sv
